// File: include/gasket_cfg.svh
/* Stream widths for the host channel gasket, included by the RTL, the package
   and the testbench. The wide side is always twice the narrow side */
`ifndef GASKET_CFG_SVH
`define GASKET_CFG_SVH

// Host link beat width
`define GASKET_NARROW_BITS 64
`define GASKET_WIDE_BITS   (2 * `GASKET_NARROW_BITS)   // Accelerator beat

// One keep bit per byte
`define GASKET_NARROW_KEEP (`GASKET_NARROW_BITS / 8)
`define GASKET_WIDE_KEEP   (`GASKET_WIDE_BITS / 8)

`endif

// File: src/gasket_pkg.sv
/* Types shared by the gasket RTL: beat field vectors for both widths and the
   state used when pairing or splitting beats */
`default_nettype none

`include "gasket_cfg.svh"

package gasket_pkg;

    // Narrow (host link) beat fields
    typedef logic [`GASKET_NARROW_BITS-1:0] narrow_data_t;
    typedef logic [`GASKET_NARROW_KEEP-1:0] narrow_keep_t;

    // Wide (accelerator) beat fields
    typedef logic [`GASKET_WIDE_BITS-1:0]   wide_data_t;
    typedef logic [`GASKET_WIDE_KEEP-1:0]   wide_keep_t;

    // Whether half a wide beat is waiting in the holding register
    typedef enum logic
    {
        HALF_EMPTY = 1'b0,
        HALF_HELD  = 1'b1
    } pair_state_e;

endpackage

`default_nettype wire

// File: src/stream_skid.sv
/* Two-entry skid buffer for a narrow valid/ready stream. Registers both the
   forward path and in_tready, adding one cycle of latency */
`timescale 1ns/1ns
`default_nettype none

`include "gasket_cfg.svh"

module stream_skid
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic                     in_tvalid,
    output logic                     in_tready,
    input  gasket_pkg::narrow_data_t in_tdata,
    input  gasket_pkg::narrow_keep_t in_tkeep,
    input  logic                     in_tlast,
    input  logic                     in_tsop,

    output logic                     out_tvalid,
    input  logic                     out_tready,
    output gasket_pkg::narrow_data_t out_tdata,
    output gasket_pkg::narrow_keep_t out_tkeep,
    output logic                     out_tlast,
    output logic                     out_tsop
);
    import gasket_pkg::*;

    narrow_data_t spare_tdata;
    narrow_keep_t spare_tkeep;
    logic         spare_tlast;
    logic         spare_tsop;
    logic         spare_valid;
    logic         spare_next;
    logic         in_xfer;
    logic         main_load;

    assign in_xfer   = in_tvalid && in_tready;
    assign main_load = !out_tvalid || out_tready;   // Main register free this cycle

    always_comb
    begin
        spare_next = spare_valid;
        if (main_load)
            spare_next = 1'b0;      // Spare drains into main
        else if (in_xfer)
            spare_next = 1'b1;      // Main stalled, park the new beat
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            out_tvalid  <= 1'b0;
            spare_valid <= 1'b0;
            in_tready   <= 1'b1;
        end
        else
        begin
            if (main_load)
                out_tvalid <= spare_valid || in_xfer;
            spare_valid <= spare_next;
            in_tready   <= !spare_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_load && spare_valid)
        begin
            out_tdata <= spare_tdata;
            out_tkeep <= spare_tkeep;
            out_tlast <= spare_tlast;
            out_tsop  <= spare_tsop;
        end
        else if (main_load && in_xfer)
        begin
            out_tdata <= in_tdata;
            out_tkeep <= in_tkeep;
            out_tlast <= in_tlast;
            out_tsop  <= in_tsop;
        end
        else if (in_xfer)
        begin
            spare_tdata <= in_tdata;
            spare_tkeep <= in_tkeep;
            spare_tlast <= in_tlast;
            spare_tsop  <= in_tsop;
        end
    end

    // A stalled output beat stays put until it is taken
    a_out_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (out_tvalid && !out_tready) |=>
            (out_tvalid && $stable({out_tdata, out_tkeep, out_tlast, out_tsop})))
        else $error("stream_skid: output beat changed while stalled");

endmodule

`default_nettype wire

// File: src/narrow_to_wide.sv
/* Receive combiner. Joins consecutive narrow beats of a packet into one wide beat,
   low half first; a lone final beat leaves with its upper half zeroed */
`timescale 1ns/1ns
`default_nettype none

`include "gasket_cfg.svh"

module narrow_to_wide
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic                     in_tvalid,
    output logic                     in_tready,
    input  gasket_pkg::narrow_data_t in_tdata,
    input  gasket_pkg::narrow_keep_t in_tkeep,
    input  logic                     in_tlast,
    input  logic                     in_tsop,

    output logic                     out_tvalid,
    input  logic                     out_tready,
    output gasket_pkg::wide_data_t   out_tdata,
    output gasket_pkg::wide_keep_t   out_tkeep,
    output logic                     out_tlast,
    output logic                     out_tsop
);
    import gasket_pkg::*;

    pair_state_e  state;
    narrow_data_t held_tdata;
    narrow_keep_t held_tkeep;
    logic         held_tsop;
    logic         in_xfer;

    // A wide beat is ready once the pair is complete or the packet ends
    assign out_tvalid = in_tvalid && (state == HALF_HELD || in_tlast);
    assign in_tready  = out_tready || (state == HALF_EMPTY && !in_tlast);
    assign in_xfer    = in_tvalid && in_tready;

    always_comb
    begin
        out_tlast = in_tlast;
        if (state == HALF_HELD)
        begin
            out_tdata = {in_tdata, held_tdata};
            out_tkeep = {in_tkeep, held_tkeep};
            out_tsop  = held_tsop;      // Start of packet comes from the low beat
        end
        else
        begin
            out_tdata = {{`GASKET_NARROW_BITS{1'b0}}, in_tdata};
            out_tkeep = {{`GASKET_NARROW_KEEP{1'b0}}, in_tkeep};
            out_tsop  = in_tsop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= HALF_EMPTY;
        else if (in_xfer)
        begin
            if (state == HALF_EMPTY && !in_tlast)
                state <= HALF_HELD;
            else
                state <= HALF_EMPTY;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_xfer && state == HALF_EMPTY)
        begin
            held_tdata <= in_tdata;
            held_tkeep <= in_tkeep;
            held_tsop  <= in_tsop;
        end
    end

    // Only a final beat may be partial, so a held low half is always full
    a_held_full: assert property (@(posedge clk) disable iff (!reset_n)
        (out_tvalid && state == HALF_HELD) |-> (&out_tkeep[`GASKET_NARROW_KEEP-1:0]))
        else $error("narrow_to_wide: held low half has a partial keep");

endmodule

`default_nettype wire

// File: src/wide_to_narrow.sv
/* Transmit splitter. Sends the low half of each wide beat at once, then the
   stored high half on the following cycle when it holds any bytes */
`timescale 1ns/1ns
`default_nettype none

`include "gasket_cfg.svh"

module wide_to_narrow
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic                     in_tvalid,
    output logic                     in_tready,
    input  gasket_pkg::wide_data_t   in_tdata,
    input  gasket_pkg::wide_keep_t   in_tkeep,
    input  logic                     in_tlast,
    input  logic                     in_tsop,

    output logic                     out_tvalid,
    input  logic                     out_tready,
    output gasket_pkg::narrow_data_t out_tdata,
    output gasket_pkg::narrow_keep_t out_tkeep,
    output logic                     out_tlast,
    output logic                     out_tsop
);
    import gasket_pkg::*;

    pair_state_e  state;
    narrow_data_t held_tdata;
    narrow_keep_t held_tkeep;
    logic         held_tlast;
    logic         high_empty;
    logic         in_xfer;

    assign high_empty = ~|in_tkeep[`GASKET_WIDE_KEEP-1:`GASKET_NARROW_KEEP];
    assign in_tready  = out_tready && (state == HALF_EMPTY);   // Stall while high half waits
    assign in_xfer    = in_tvalid && in_tready;
    assign out_tvalid = in_tvalid || (state == HALF_HELD);

    always_comb
    begin
        if (state == HALF_HELD)
        begin
            out_tdata = held_tdata;
            out_tkeep = held_tkeep;
            out_tlast = held_tlast;
            out_tsop  = 1'b0;
        end
        else
        begin
            out_tdata = in_tdata[`GASKET_NARROW_BITS-1:0];
            out_tkeep = in_tkeep[`GASKET_NARROW_KEEP-1:0];
            out_tlast = in_tlast && high_empty;   // No second half to follow
            out_tsop  = in_tsop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= HALF_EMPTY;
        else if (state == HALF_HELD)
        begin
            if (out_tready)
                state <= HALF_EMPTY;
        end
        else if (in_xfer && !high_empty)
            state <= HALF_HELD;
    end

    always_ff @(posedge clk)
    begin
        if (in_xfer)
        begin
            held_tdata <= in_tdata[`GASKET_WIDE_BITS-1:`GASKET_NARROW_BITS];
            held_tkeep <= in_tkeep[`GASKET_WIDE_KEEP-1:`GASKET_NARROW_KEEP];
            held_tlast <= in_tlast;
        end
    end

    // Keep must be contiguous from byte 0
    a_keep_contig: assert property (@(posedge clk) disable iff (!reset_n)
        (in_tvalid && !high_empty) |-> (&in_tkeep[`GASKET_NARROW_KEEP-1:0]))
        else $error("wide_to_narrow: high keep set with a partial low half");

endmodule

`default_nettype wire

// File: src/host_chan_gasket.sv
/* Top of the host channel width gasket. Receive path packs host beats for the
   accelerator, transmit path splits accelerator beats for the host */
`timescale 1ns/1ns
`default_nettype none

`include "gasket_cfg.svh"

module host_chan_gasket
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic                     host_rx_tvalid,
    output logic                     host_rx_tready,
    input  gasket_pkg::narrow_data_t host_rx_tdata,
    input  gasket_pkg::narrow_keep_t host_rx_tkeep,
    input  logic                     host_rx_tlast,
    input  logic                     host_rx_tsop,

    output logic                     afu_rx_tvalid,
    input  logic                     afu_rx_tready,
    output gasket_pkg::wide_data_t   afu_rx_tdata,
    output gasket_pkg::wide_keep_t   afu_rx_tkeep,
    output logic                     afu_rx_tlast,
    output logic                     afu_rx_tsop,

    input  logic                     afu_tx_tvalid,
    output logic                     afu_tx_tready,
    input  gasket_pkg::wide_data_t   afu_tx_tdata,
    input  gasket_pkg::wide_keep_t   afu_tx_tkeep,
    input  logic                     afu_tx_tlast,
    input  logic                     afu_tx_tsop,

    output logic                     host_tx_tvalid,
    input  logic                     host_tx_tready,
    output gasket_pkg::narrow_data_t host_tx_tdata,
    output gasket_pkg::narrow_keep_t host_tx_tkeep,
    output logic                     host_tx_tlast,
    output logic                     host_tx_tsop
);
    import gasket_pkg::*;

    // Receive skid to combiner
    logic         rx_mid_tvalid;
    logic         rx_mid_tready;
    narrow_data_t rx_mid_tdata;
    narrow_keep_t rx_mid_tkeep;
    logic         rx_mid_tlast;
    logic         rx_mid_tsop;

    // Splitter to transmit skid
    logic         tx_mid_tvalid;
    logic         tx_mid_tready;
    narrow_data_t tx_mid_tdata;
    narrow_keep_t tx_mid_tkeep;
    logic         tx_mid_tlast;
    logic         tx_mid_tsop;

    stream_skid rx_skid
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_tvalid  (host_rx_tvalid),
        .in_tready  (host_rx_tready),
        .in_tdata   (host_rx_tdata),
        .in_tkeep   (host_rx_tkeep),
        .in_tlast   (host_rx_tlast),
        .in_tsop    (host_rx_tsop),
        .out_tvalid (rx_mid_tvalid),
        .out_tready (rx_mid_tready),
        .out_tdata  (rx_mid_tdata),
        .out_tkeep  (rx_mid_tkeep),
        .out_tlast  (rx_mid_tlast),
        .out_tsop   (rx_mid_tsop)
    );

    narrow_to_wide rx_pack
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_tvalid  (rx_mid_tvalid),
        .in_tready  (rx_mid_tready),
        .in_tdata   (rx_mid_tdata),
        .in_tkeep   (rx_mid_tkeep),
        .in_tlast   (rx_mid_tlast),
        .in_tsop    (rx_mid_tsop),
        .out_tvalid (afu_rx_tvalid),
        .out_tready (afu_rx_tready),
        .out_tdata  (afu_rx_tdata),
        .out_tkeep  (afu_rx_tkeep),
        .out_tlast  (afu_rx_tlast),
        .out_tsop   (afu_rx_tsop)
    );

    wide_to_narrow tx_split
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_tvalid  (afu_tx_tvalid),
        .in_tready  (afu_tx_tready),
        .in_tdata   (afu_tx_tdata),
        .in_tkeep   (afu_tx_tkeep),
        .in_tlast   (afu_tx_tlast),
        .in_tsop    (afu_tx_tsop),
        .out_tvalid (tx_mid_tvalid),
        .out_tready (tx_mid_tready),
        .out_tdata  (tx_mid_tdata),
        .out_tkeep  (tx_mid_tkeep),
        .out_tlast  (tx_mid_tlast),
        .out_tsop   (tx_mid_tsop)
    );

    stream_skid tx_skid
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_tvalid  (tx_mid_tvalid),
        .in_tready  (tx_mid_tready),
        .in_tdata   (tx_mid_tdata),
        .in_tkeep   (tx_mid_tkeep),
        .in_tlast   (tx_mid_tlast),
        .in_tsop    (tx_mid_tsop),
        .out_tvalid (host_tx_tvalid),
        .out_tready (host_tx_tready),
        .out_tdata  (host_tx_tdata),
        .out_tkeep  (host_tx_tkeep),
        .out_tlast  (host_tx_tlast),
        .out_tsop   (host_tx_tsop)
    );

endmodule

`default_nettype wire

// File: verif/gasket_model.sv
/* Reference model for the gasket testbench. Turns each sent beat into the expected
   output beats of its direction and hands them back in order */
`timescale 1ns/1ns
`default_nettype none

`include "gasket_cfg.svh"

module gasket_model;
    import gasket_pkg::*;

    typedef struct packed
    {
        logic       sop;
        logic       last;
        wide_keep_t keep;
        wide_data_t data;
    } wide_beat_t;

    typedef struct packed
    {
        logic         sop;
        logic         last;
        narrow_keep_t keep;
        narrow_data_t data;
    } narrow_beat_t;

    wide_beat_t   rx_q[$];          // Expected on afu_rx
    narrow_beat_t tx_q[$];          // Expected on host_tx
    logic         half_held = 1'b0;
    narrow_beat_t low_half;         // First beat of an open pair

    // Host beats pair up, the earlier beat in the low half
    task automatic add_rx_beat(input narrow_data_t data, input narrow_keep_t keep,
                               input logic last, input logic sop);
        wide_beat_t b;
        if (!half_held && !last)
        begin
            low_half  = {sop, last, keep, data};
            half_held = 1'b1;
        end
        else if (!half_held)
        begin
            b = {sop, last, {`GASKET_NARROW_KEEP{1'b0}}, keep, {`GASKET_NARROW_BITS{1'b0}}, data};
            rx_q.push_back(b);      // Lone final beat
        end
        else
        begin
            b = {low_half.sop, last, keep, low_half.keep, data, low_half.data};
            rx_q.push_back(b);
            half_held = 1'b0;
        end
    endtask

    task automatic add_tx_beat(input wide_data_t data, input wide_keep_t keep,
                               input logic last, input logic sop);
        narrow_keep_t high_keep;
        narrow_beat_t b;
        high_keep = keep[`GASKET_WIDE_KEEP-1:`GASKET_NARROW_KEEP];
        b = {sop, last && (high_keep == '0), keep[`GASKET_NARROW_KEEP-1:0],
             data[`GASKET_NARROW_BITS-1:0]};
        tx_q.push_back(b);
        if (high_keep != '0)
        begin
            b = {1'b0, last, high_keep, data[`GASKET_WIDE_BITS-1:`GASKET_NARROW_BITS]};
            tx_q.push_back(b);
        end
    endtask

    task automatic next_rx(output wide_data_t data, output wide_keep_t keep,
                           output logic last, output logic sop, output logic found);
        wide_beat_t b;
        b     = '0;
        found = 1'b0;
        if (rx_q.size() != 0)
        begin
            b     = rx_q.pop_front();
            found = 1'b1;
        end
        {sop, last, keep, data} = b;
    endtask

    task automatic next_tx(output narrow_data_t data, output narrow_keep_t keep,
                           output logic last, output logic sop, output logic found);
        narrow_beat_t b;
        b     = '0;
        found = 1'b0;
        if (tx_q.size() != 0)
        begin
            b     = tx_q.pop_front();
            found = 1'b1;
        end
        {sop, last, keep, data} = b;
    endtask

    function automatic int rx_left();
        return rx_q.size();
    endfunction

    function automatic int tx_left();
        return tx_q.size();
    endfunction

endmodule

`default_nettype wire

// File: verif/gasket_tb.sv
/* Testbench for the host channel gasket. Sends random packets both ways under
   random back-pressure and checks every output beat against the model */
`timescale 1ns/1ns
`default_nettype none

`include "gasket_cfg.svh"

module gasket_tb;
    import gasket_pkg::*;

    localparam int PACKETS     = 200;      // Per direction
    localparam int CYCLE_NS    = 10;
    localparam int WATCHDOG_NS = 2 * PACKETS * 400 * CYCLE_NS;

    logic         clk;
    logic         reset_n;
    logic         host_rx_tvalid, host_rx_tready, host_rx_tlast, host_rx_tsop;
    narrow_data_t host_rx_tdata;
    narrow_keep_t host_rx_tkeep;
    logic         afu_rx_tvalid, afu_rx_tready, afu_rx_tlast, afu_rx_tsop;
    wide_data_t   afu_rx_tdata;
    wide_keep_t   afu_rx_tkeep;
    logic         afu_tx_tvalid, afu_tx_tready, afu_tx_tlast, afu_tx_tsop;
    wide_data_t   afu_tx_tdata;
    wide_keep_t   afu_tx_tkeep;
    logic         host_tx_tvalid, host_tx_tready, host_tx_tlast, host_tx_tsop;
    narrow_data_t host_tx_tdata;
    narrow_keep_t host_tx_tkeep;
    integer       seed = 50360;

    host_chan_gasket DUT (.*);
    gasket_model model ();

    always #(CYCLE_NS / 2) clk = ~clk;

    task automatic stop_on_failure;
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_value(input logic [127:0] got, input logic [127:0] expected,
                                 input string what);
        if (got !== expected)
        begin
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    function automatic int rand_below(input int n);
        int unsigned r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // Contiguous keep from byte 0
    function automatic wide_keep_t fill_keep(input int bytes);
        wide_keep_t k;
        for (int i = 0; i < `GASKET_WIDE_KEEP; i++)
            k[i] = (i < bytes);
        return k;
    endfunction

    task automatic send_rx_packets;
        int           len;
        narrow_data_t data;
        wide_keep_t   wk;
        logic         last;
        logic         sop;
        for (int p = 0; p < PACKETS; p++)
        begin
            len = 1 + rand_below(9);
            for (int i = 0; i < len; i++)
            begin
                data = {$random(seed), $random(seed)};
                last = (i == len - 1);
                sop  = (i == 0);
                wk   = fill_keep(last ? 1 + rand_below(8) : 8);
                model.add_rx_beat(data, wk[`GASKET_NARROW_KEEP-1:0], last, sop);
                host_rx_tvalid <= 1'b1;
                host_rx_tdata  <= data;
                host_rx_tkeep  <= wk[`GASKET_NARROW_KEEP-1:0];
                host_rx_tlast  <= last;
                host_rx_tsop   <= sop;
                @(posedge clk);
                while (!host_rx_tready)
                    @(posedge clk);
            end
        end
        host_rx_tvalid <= 1'b0;
    endtask

    task automatic send_tx_packets;
        int         len;
        wide_data_t data;
        wide_keep_t keep;
        logic       last;
        logic       sop;
        for (int p = 0; p < PACKETS; p++)
        begin
            len = 1 + rand_below(5);
            for (int i = 0; i < len; i++)
            begin
                data = {$random(seed), $random(seed), $random(seed), $random(seed)};
                last = (i == len - 1);
                sop  = (i == 0);
                keep = fill_keep(last ? 1 + rand_below(16) : 16);
                model.add_tx_beat(data, keep, last, sop);
                afu_tx_tvalid <= 1'b1;
                afu_tx_tdata  <= data;
                afu_tx_tkeep  <= keep;
                afu_tx_tlast  <= last;
                afu_tx_tsop   <= sop;
                @(posedge clk);
                while (!afu_tx_tready)
                    @(posedge clk);
            end
        end
        afu_tx_tvalid <= 1'b0;
    endtask

    task automatic check_rx_beat;
        wide_data_t data;
        wide_keep_t keep;
        logic       last;
        logic       sop;
        logic       found;
        model.next_rx(data, keep, last, sop, found);
        if (!found)
        begin
            $display("Error at %0t ns: afu_rx delivered a beat that no sent packet explains",
                     $time);
            stop_on_failure();
        end
        else
        begin
            compare_value(afu_rx_tdata, data, "afu_rx_tdata");
            compare_value(128'(afu_rx_tkeep), 128'(keep), "afu_rx_tkeep");
            compare_value(128'(afu_rx_tlast), 128'(last), "afu_rx_tlast");
            compare_value(128'(afu_rx_tsop), 128'(sop), "afu_rx_tsop");
        end
    endtask

    task automatic check_tx_beat;
        narrow_data_t data;
        narrow_keep_t keep;
        logic         last;
        logic         sop;
        logic         found;
        model.next_tx(data, keep, last, sop, found);
        if (!found)
        begin
            $display("Error at %0t ns: host_tx delivered a beat that no sent packet explains",
                     $time);
            stop_on_failure();
        end
        else
        begin
            compare_value(128'(host_tx_tdata), 128'(data), "host_tx_tdata");
            compare_value(128'(host_tx_tkeep), 128'(keep), "host_tx_tkeep");
            compare_value(128'(host_tx_tlast), 128'(last), "host_tx_tlast");
            compare_value(128'(host_tx_tsop), 128'(sop), "host_tx_tsop");
        end
    endtask

    // Sinks take about 70% of cycles
    always @(posedge clk)
    begin
        afu_rx_tready  <= (rand_below(10) < 7);
        host_tx_tready <= (rand_below(10) < 7);
    end

    always @(posedge clk)
    begin
        if (reset_n && afu_rx_tvalid && afu_rx_tready)
            check_rx_beat();
        if (reset_n && host_tx_tvalid && host_tx_tready)
            check_tx_beat();
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        stop_on_failure();
    end

    initial
    begin
        clk            = 1'b0;
        reset_n        = 1'b0;
        host_rx_tvalid = 1'b0;
        host_rx_tdata  = '0;
        host_rx_tkeep  = '0;
        host_rx_tlast  = 1'b0;
        host_rx_tsop   = 1'b0;
        afu_tx_tvalid  = 1'b0;
        afu_tx_tdata   = '0;
        afu_tx_tkeep   = '0;
        afu_tx_tlast   = 1'b0;
        afu_tx_tsop    = 1'b0;
        afu_rx_tready  = 1'b0;
        host_tx_tready = 1'b0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        compare_value(128'(afu_rx_tvalid), 128'(0), "afu_rx_tvalid after reset");
        compare_value(128'(host_tx_tvalid), 128'(0), "host_tx_tvalid after reset");
        compare_value(128'(host_rx_tready), 128'(1), "host_rx_tready after reset");
        fork
            send_rx_packets();
            send_tx_packets();
        join
        while (model.rx_left() != 0 || model.tx_left() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);      // Room for a surplus beat to show
        if (!afu_rx_tvalid && !host_tx_tvalid)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("Error: an output still offered a beat after all packets were delivered");
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
src/gasket_pkg.sv
src/stream_skid.sv
src/narrow_to_wide.sv
src/wide_to_narrow.sv
src/host_chan_gasket.sv
verif/gasket_model.sv
verif/gasket_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the gasket testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sources.f --top-module gasket_tb -o gasket_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/gasket_sim > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation gave no result"; exit 1; }
exit 0
